/* sources.f */
hdl/dma_chan_pkg.sv
hdl/chan_bus_slave.sv
hdl/chan_cfg_regs.sv
hdl/chan_irq_ctrl.sv
hdl/dma_chan_regs.sv
sim/dma_chan_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for failures

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module dma_chan_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdma_chan_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation finished without failures"
exit 0

/* sim/dma_chan_tb.sv */
// Testbench for the DMA channel register block at base 0x30
// The transfer engine is modelled by driving evt and en_clr directly
// Each zero-wait bus transfer takes one address cycle and one data cycle
module dma_chan_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam dma_chan_pkg::dec_addr_t BASE_ADDR = 10'h030;
  localparam int EST_CYCLES = 400;  // Bus traffic and event pulses of all six tests
  localparam int MAX_CYCLES = 5 * EST_CYCLES;
  localparam dma_chan_pkg::reg_word_t CA_MASK  = 32'hB7FF_FFFF;
  localparam dma_chan_pkg::reg_word_t CB_MASK  = 32'h0007_E007;
  localparam dma_chan_pkg::reg_word_t GX_MASK  = 32'h0000_0003;
  localparam dma_chan_pkg::reg_word_t IRQ_MASK = 32'h0000_001F;

  logic                    hclk;
  logic                    hrst_n;
  dma_chan_pkg::ahb_req_t  s_req;
  dma_chan_pkg::reg_word_t s_wdata;
  dma_chan_pkg::reg_word_t s_rdata;
  dma_chan_pkg::irq_vec_t  evt;
  logic                    en_clr;
  dma_chan_pkg::chan_cfg_t cfg;
  logic                    chan_en;
  logic                    soft_trig;
  logic                    irq;
  logic                    pend;

  logic                    dp_wr;  // Live write in its data phase
  dma_chan_pkg::dec_addr_t dp_ofs;
  dma_chan_pkg::reg_word_t dp_data;
  dma_chan_pkg::irq_vec_t  exp_mask;
  dma_chan_pkg::irq_vec_t  exp_status;
  dma_chan_pkg::irq_vec_t  exp_clr;
  logic                    exp_ie;
  logic                    exp_en;
  logic                    exp_trig;
  dma_chan_pkg::chan_cfg_t exp_cfg;

  logic [7:0]              lfsr_q;
  int                      n_checks;
  int                      n_errs;
  int                      n_prop_errs;
  int                      errs_at_start;
  int                      cycles;
  dma_chan_pkg::reg_word_t sa, da, ca, cb, gx, acc, w, got;

  dma_chan_regs #(.BASE_ADDR(BASE_ADDR)) dma_chan_regs_i (.*);

  initial begin
    hclk = 1'b0;
    forever #50 hclk = ~hclk;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge hclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and output rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      exp_mask   <= '0;
      exp_status <= '0;
      exp_clr    <= '0;
      exp_ie     <= 1'b0;
      exp_en     <= 1'b0;
      exp_trig   <= 1'b0;
    end else begin
      exp_status <= evt | (exp_status & ~exp_clr);  // Event beats clear
      exp_clr    <= (dp_wr && dp_ofs == dma_chan_pkg::OFS_INT_CLEAR) ? dp_data[4:0] : '0;
      exp_trig   <= dp_wr && dp_ofs == dma_chan_pkg::OFS_SOFT_REQ && dp_data[0];
      if (dp_wr && dp_ofs == dma_chan_pkg::OFS_INT_MASK) exp_mask <= dp_data[4:0];
      if (dp_wr && dp_ofs == dma_chan_pkg::OFS_CTRL_B && !exp_en) exp_ie <= dp_data[0];
      if (dp_wr && dp_ofs == dma_chan_pkg::OFS_EN) exp_en <= dp_data[0];
      else if (en_clr) exp_en <= 1'b0;
    end
  end

  irq_rule: assert property (@(negedge hclk) disable iff (!hrst_n)
      irq == (exp_ie & (|(exp_status & exp_mask))))
    else begin
      n_prop_errs++;
      $display("CHECK FAILED at %0t: irq got %b expected %b", $time, irq,
               exp_ie & (|(exp_status & exp_mask)));
    end
  pend_rule: assert property (@(negedge hclk) disable iff (!hrst_n) pend == exp_status[4])
    else begin
      n_prop_errs++;
      $display("CHECK FAILED at %0t: pend got %b expected %b", $time, pend, exp_status[4]);
    end
  trig_rule: assert property (@(negedge hclk) disable iff (!hrst_n) soft_trig == exp_trig)
    else begin
      n_prop_errs++;
      $display("CHECK FAILED at %0t: soft_trig got %b expected %b", $time, soft_trig, exp_trig);
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Taps 8, 6, 5, 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic dma_chan_pkg::reg_word_t take_bits(input int n);
    dma_chan_pkg::reg_word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic dma_chan_pkg::reg_word_t reg_addr(input dma_chan_pkg::dec_addr_t ofs);
    return {22'b0, BASE_ADDR + ofs};
  endfunction

  task automatic check_value(input string name, input dma_chan_pkg::reg_word_t got_v,
                             input dma_chan_pkg::reg_word_t exp_v);
    n_checks++;
    assert (got_v == exp_v) else begin
      n_errs++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got_v, exp_v);
    end
  endtask

  task automatic bus_xfer(input logic sel, input dma_chan_pkg::htrans_e trans,
                          input logic wr, input dma_chan_pkg::reg_word_t addr,
                          input dma_chan_pkg::reg_word_t data,
                          output dma_chan_pkg::reg_word_t rdata);
    s_req.sel   = sel;
    s_req.trans = trans;
    s_req.addr  = addr;
    s_req.write = wr;
    @(negedge hclk);
    rdata       = s_rdata;  // Data phase
    s_req.sel   = 1'b0;
    s_req.trans = dma_chan_pkg::IDLE;
    s_wdata     = data;
    dp_wr       = sel && wr && (trans == dma_chan_pkg::NONSEQ || trans == dma_chan_pkg::SEQ);
    dp_ofs      = addr[9:0] - BASE_ADDR;
    dp_data     = data;
    @(negedge hclk);
    dp_wr = 1'b0;
  endtask

  task automatic reg_write(input dma_chan_pkg::dec_addr_t ofs, input dma_chan_pkg::reg_word_t d);
    dma_chan_pkg::reg_word_t unused_rd;
    bus_xfer(1'b1, dma_chan_pkg::NONSEQ, 1'b1, reg_addr(ofs), d, unused_rd);
  endtask

  task automatic reg_read_check(input string name, input dma_chan_pkg::dec_addr_t ofs,
                                input dma_chan_pkg::reg_word_t exp_v);
    dma_chan_pkg::reg_word_t rd;
    bus_xfer(1'b1, dma_chan_pkg::NONSEQ, 1'b0, reg_addr(ofs), '0, rd);
    check_value(name, rd, exp_v);
  endtask

  task automatic fire_events(input dma_chan_pkg::irq_vec_t ev);
    evt = ev;
    @(negedge hclk);
    evt = '0;
  endtask

  task automatic pulse_en_clr();
    en_clr = 1'b1;
    @(negedge hclk);
    en_clr = 1'b0;
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = n_errs + n_prop_errs - errs_at_start;
    $display("Test %s finished with %0d errors", name, errs);
    errs_at_start = n_errs + n_prop_errs;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    hrst_n  = 1'b0;
    s_req   = '0;
    s_wdata = '0;
    evt     = '0;
    en_clr  = 1'b0;
    dp_wr   = 1'b0;
    dp_ofs  = '0;
    dp_data = '0;
    lfsr_q  = 8'd88;
    repeat (4) @(negedge hclk);
    hrst_n = 1'b1;
    @(negedge hclk);

    for (int r = 0; r < 3; r++) begin
      sa = take_bits(32);
      da = take_bits(32);
      ca = take_bits(32);
      cb = take_bits(32);
      gx = take_bits(32);
      reg_write(dma_chan_pkg::OFS_SARN, sa);
      reg_write(dma_chan_pkg::OFS_DARN, da);
      reg_write(dma_chan_pkg::OFS_CTRL_A, ca);
      reg_write(dma_chan_pkg::OFS_CTRL_B, cb);
      reg_write(dma_chan_pkg::OFS_GRP_EXT, gx);
      reg_read_check("sarn", dma_chan_pkg::OFS_SARN, sa);
      reg_read_check("darn", dma_chan_pkg::OFS_DARN, da);
      reg_read_check("ctrl_a", dma_chan_pkg::OFS_CTRL_A, ca & CA_MASK);
      reg_read_check("ctrl_b", dma_chan_pkg::OFS_CTRL_B, cb & CB_MASK);
      reg_read_check("grp_ext", dma_chan_pkg::OFS_GRP_EXT, gx & GX_MASK);
      exp_cfg = {sa, da, ca[31], ca[29], ca[28], ca[26:24], ca[23:12], gx[1:0], ca[11:8],
                 ca[7:6], ca[5:4], ca[3:2], ca[1:0], cb[18:15], cb[14], cb[13], cb[2:1]};
      n_checks++;
      assert (cfg == exp_cfg) else begin
        n_errs++;
        $display("CHECK FAILED at %0t: cfg got %h expected %h", $time, cfg, exp_cfg);
      end
    end
    report_test("read_back");

    reg_write(dma_chan_pkg::OFS_EN, 32'h1);
    check_value("chan_en", {31'b0, chan_en}, 32'h1);
    reg_read_check("en", dma_chan_pkg::OFS_EN, 32'h1);
    reg_write(dma_chan_pkg::OFS_SARN, ~sa);
    reg_write(dma_chan_pkg::OFS_DARN, ~da);
    reg_write(dma_chan_pkg::OFS_CTRL_A, ~ca);
    reg_write(dma_chan_pkg::OFS_CTRL_B, ~cb);
    reg_write(dma_chan_pkg::OFS_GRP_EXT, ~gx);
    w = take_bits(5);
    reg_write(dma_chan_pkg::OFS_INT_MASK, w);
    reg_read_check("sarn locked", dma_chan_pkg::OFS_SARN, sa);
    reg_read_check("darn locked", dma_chan_pkg::OFS_DARN, da);
    reg_read_check("ctrl_a locked", dma_chan_pkg::OFS_CTRL_A, ca & CA_MASK);
    reg_read_check("ctrl_b locked", dma_chan_pkg::OFS_CTRL_B, cb & CB_MASK);
    reg_read_check("grp_ext locked", dma_chan_pkg::OFS_GRP_EXT, gx & GX_MASK);
    reg_read_check("int_mask", dma_chan_pkg::OFS_INT_MASK, w);
    pulse_en_clr();
    reg_read_check("en cleared", dma_chan_pkg::OFS_EN, '0);
    sa = take_bits(32);
    reg_write(dma_chan_pkg::OFS_SARN, sa);
    reg_read_check("sarn unlocked", dma_chan_pkg::OFS_SARN, sa);
    en_clr = 1'b1;  // Held across both edges of the enable write
    reg_write(dma_chan_pkg::OFS_EN, 32'h1);
    en_clr = 1'b0;
    reg_read_check("en over en_clr", dma_chan_pkg::OFS_EN, 32'h1);
    pulse_en_clr();
    report_test("lock");

    acc = '0;
    for (int i = 0; i < 12; i++) begin
      if (i % 4 == 0) begin
        reg_write(dma_chan_pkg::OFS_INT_CLEAR, IRQ_MASK);
        acc = '0;
      end
      reg_write(dma_chan_pkg::OFS_CTRL_B, take_bits(32));
      reg_write(dma_chan_pkg::OFS_INT_MASK, take_bits(5));
      w = take_bits(5) & take_bits(5);
      fire_events(w[4:0]);
      acc = acc | w;
      reg_read_check("int_status", dma_chan_pkg::OFS_INT_STATUS, acc);
    end
    report_test("irq_combine");

    for (int i = 0; i < 6; i++) begin
      fire_events(5'h1F);
      w = take_bits(5);
      reg_write(dma_chan_pkg::OFS_INT_CLEAR, w);
      check_value("pend before clear edge", {31'b0, pend}, 32'h1);
      reg_read_check("int_status cleared", dma_chan_pkg::OFS_INT_STATUS, IRQ_MASK & ~w);
      acc = take_bits(5);
      reg_write(dma_chan_pkg::OFS_INT_CLEAR, IRQ_MASK);
      fire_events(acc[4:0]);  // Lands on the clear edge
      reg_read_check("int_status kept", dma_chan_pkg::OFS_INT_STATUS, acc);
    end
    report_test("clear");

    reg_write(dma_chan_pkg::OFS_SOFT_REQ, 32'h1);
    check_value("soft_trig", {31'b0, soft_trig}, 32'h1);
    @(negedge hclk);
    check_value("soft_trig after pulse", {31'b0, soft_trig}, '0);
    reg_write(dma_chan_pkg::OFS_SOFT_REQ, 32'hFFFF_FFFE);
    check_value("soft_trig on zero", {31'b0, soft_trig}, '0);
    report_test("soft_trig");

    reg_write(dma_chan_pkg::OFS_INT_MASK, 32'h0A);
    bus_xfer(1'b1, dma_chan_pkg::IDLE, 1'b1, reg_addr(dma_chan_pkg::OFS_SARN), ~sa, got);
    bus_xfer(1'b1, dma_chan_pkg::BUSY, 1'b1, reg_addr(dma_chan_pkg::OFS_SARN), ~sa, got);
    bus_xfer(1'b0, dma_chan_pkg::NONSEQ, 1'b1, reg_addr(dma_chan_pkg::OFS_SARN), ~sa, got);
    bus_xfer(1'b0, dma_chan_pkg::SEQ, 1'b1, reg_addr(dma_chan_pkg::OFS_INT_MASK), '1, got);
    bus_xfer(1'b1, dma_chan_pkg::NONSEQ, 1'b1, reg_addr(10'h028), ~sa, got);
    reg_read_check("sarn untouched", dma_chan_pkg::OFS_SARN, sa);
    reg_read_check("int_mask untouched", dma_chan_pkg::OFS_INT_MASK, 32'h0A);
    bus_xfer(1'b1, dma_chan_pkg::IDLE, 1'b0, reg_addr(dma_chan_pkg::OFS_SARN), '0, got);
    check_value("idle read", got, '0);
    reg_read_check("soft_req read", dma_chan_pkg::OFS_SOFT_REQ, '0);
    reg_read_check("int_clear read", dma_chan_pkg::OFS_INT_CLEAR, '0);
    reg_read_check("unmapped read", 10'h028, '0);
    report_test("ignored");

    $display("Checks: %0d, errors: %0d", n_checks, n_errs + n_prop_errs);
    if (n_errs + n_prop_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* hdl/dma_chan_regs.sv */
// Register block of one DMA channel on a zero-wait AHB-style slave port
// BASE_ADDR is compared against the low 10 address bits only
// The transfer engine drives evt and en_clr and consumes cfg and the strobes
module dma_chan_regs #(
  parameter dma_chan_pkg::dec_addr_t BASE_ADDR = 10'h030
) (
  input  logic                    hclk,
  input  logic                    hrst_n,
  input  dma_chan_pkg::ahb_req_t  s_req,
  input  dma_chan_pkg::reg_word_t s_wdata,
  output dma_chan_pkg::reg_word_t s_rdata,
  input  dma_chan_pkg::irq_vec_t  evt,
  input  logic                    en_clr,
  output dma_chan_pkg::chan_cfg_t cfg,
  output logic                    chan_en,
  output logic                    soft_trig,
  output logic                    irq,
  output logic                    pend
);

  dma_chan_pkg::reg_sel_t  wr_sel;
  dma_chan_pkg::reg_sel_t  rd_sel;
  dma_chan_pkg::reg_word_t wdata;
  dma_chan_pkg::reg_word_t cfg_rdata;
  dma_chan_pkg::reg_word_t irq_rdata;
  logic                    int_en;

  chan_bus_slave #(
    .BASE_ADDR (BASE_ADDR)
  ) bus_slave_i (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .s_req     (s_req),
    .s_wdata   (s_wdata),
    .cfg_rdata (cfg_rdata),
    .irq_rdata (irq_rdata),
    .wr_sel    (wr_sel),
    .rd_sel    (rd_sel),
    .wdata     (wdata),
    .s_rdata   (s_rdata)
  );

  chan_cfg_regs cfg_regs_i (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .wr_sel    (wr_sel),
    .rd_sel    (rd_sel),
    .wdata     (wdata),
    .en_clr    (en_clr),
    .cfg       (cfg),
    .int_en    (int_en),
    .chan_en   (chan_en),
    .soft_trig (soft_trig),
    .cfg_rdata (cfg_rdata)
  );

  chan_irq_ctrl irq_ctrl_i (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .wr_sel    (wr_sel),
    .rd_sel    (rd_sel),
    .wdata     (wdata),
    .evt       (evt),
    .int_en    (int_en),
    .irq       (irq),
    .pend      (pend),
    .irq_rdata (irq_rdata)
  );

endmodule

/* hdl/chan_irq_ctrl.sv */
// Channel interrupt mask, sticky status and write-one-to-clear logic
// An engine event in the same cycle as a clear pulse keeps the flag set
// The channel interrupt needs int_en from control B as well as a mask bit
module chan_irq_ctrl (
  input  logic                    hclk,
  input  logic                    hrst_n,
  input  dma_chan_pkg::reg_sel_t  wr_sel,
  input  dma_chan_pkg::reg_sel_t  rd_sel,
  input  dma_chan_pkg::reg_word_t wdata,
  input  dma_chan_pkg::irq_vec_t  evt,
  input  logic                    int_en,
  output logic                    irq,
  output logic                    pend,
  output dma_chan_pkg::reg_word_t irq_rdata
);

  dma_chan_pkg::irq_vec_t mask_q;
  dma_chan_pkg::irq_vec_t status_q;
  dma_chan_pkg::irq_vec_t clr_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Mask and clear pulses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      mask_q <= '0;
      clr_q  <= '0;
    end else begin
      if (wr_sel.int_mask) begin
        mask_q <= wdata[dma_chan_pkg::IRQ_W-1:0];
      end
      // Clear bits live for one cycle only
      clr_q <= wr_sel.int_clear ? wdata[dma_chan_pkg::IRQ_W-1:0] : '0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sticky status
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      status_q <= '0;
    end else begin
      status_q <= evt | (status_q & ~clr_q);  // Set wins over clear
    end
  end

  assign irq  = int_en & (|(status_q & mask_q));
  assign pend = status_q[dma_chan_pkg::IRQ_PEND_BIT];

  always_comb begin
    irq_rdata = '0;
    if (rd_sel.int_mask) begin
      irq_rdata[dma_chan_pkg::IRQ_W-1:0] = mask_q;
    end
    if (rd_sel.int_status) begin
      irq_rdata[dma_chan_pkg::IRQ_W-1:0] = status_q;  // Pending shows at bit 4
    end
  end

endmodule

/* hdl/chan_cfg_regs.sv */
// Channel configuration, enable bit and software trigger
// Address and control writes are dropped while the channel is enabled
// A software enable write beats a same-cycle clear from the transfer engine
module chan_cfg_regs (
  input  logic                    hclk,
  input  logic                    hrst_n,
  input  dma_chan_pkg::reg_sel_t  wr_sel,
  input  dma_chan_pkg::reg_sel_t  rd_sel,
  input  dma_chan_pkg::reg_word_t wdata,
  input  logic                    en_clr,
  output dma_chan_pkg::chan_cfg_t cfg,
  output logic                    int_en,
  output logic                    chan_en,
  output logic                    soft_trig,
  output dma_chan_pkg::reg_word_t cfg_rdata
);

  dma_chan_pkg::reg_word_t ctrl_a_word;
  dma_chan_pkg::reg_word_t ctrl_b_word;
  dma_chan_pkg::reg_word_t ext_word;
  dma_chan_pkg::reg_word_t en_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      cfg    <= '0;
      int_en <= 1'b0;
    end else if (!chan_en) begin  // Locked while the engine owns the channel
      if (wr_sel.sarn) begin
        cfg.sarn <= wdata;
      end
      if (wr_sel.darn) begin
        cfg.darn <= wdata;
      end
      if (wr_sel.ctrl_a) begin
        cfg.dst_grp_addr <= wdata[dma_chan_pkg::CA_DGRP_BIT];
        cfg.src_grp_addr <= wdata[dma_chan_pkg::CA_SGRP_BIT];
        cfg.grp_mode     <= wdata[dma_chan_pkg::CA_GRPM_BIT];
        cfg.int_mode     <= wdata[dma_chan_pkg::CA_INTM_LSB +: dma_chan_pkg::INT_MODE_W];
        cfg.block_len    <= wdata[dma_chan_pkg::CA_BTL_LSB +: dma_chan_pkg::BTL_W];
        cfg.group_len[dma_chan_pkg::GLEN_LO_W-1:0] <=
          wdata[dma_chan_pkg::CA_GLEN_LSB +: dma_chan_pkg::GLEN_LO_W];
        cfg.src_inc      <= wdata[dma_chan_pkg::CA_SINC_LSB +: 2];
        cfg.dst_inc      <= wdata[dma_chan_pkg::CA_DINC_LSB +: 2];
        cfg.src_width    <= wdata[dma_chan_pkg::CA_SWID_LSB +: 2];
        cfg.dst_width    <= wdata[dma_chan_pkg::CA_DWID_LSB +: 2];
      end
      if (wr_sel.ctrl_b) begin
        cfg.prot       <= wdata[dma_chan_pkg::CB_PROT_LSB +: dma_chan_pkg::PROT_W];
        cfg.endian     <= wdata[dma_chan_pkg::CB_ENDIAN_BIT];
        cfg.src_dlogic <= wdata[dma_chan_pkg::CB_SDL_BIT];
        cfg.trig_mode  <= wdata[dma_chan_pkg::CB_TRIG_LSB +: dma_chan_pkg::TRIG_W];
        int_en         <= wdata[dma_chan_pkg::CB_IE_BIT];
      end
      if (wr_sel.grp_ext) begin
        cfg.group_len[dma_chan_pkg::GLEN_LO_W +: dma_chan_pkg::GLEN_HI_W] <=
          wdata[dma_chan_pkg::GX_GLEN_LSB +: dma_chan_pkg::GLEN_HI_W];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Enable and software trigger
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chan_en   <= 1'b0;
      soft_trig <= 1'b0;
    end else begin
      if (wr_sel.en) begin
        chan_en <= wdata[dma_chan_pkg::EN_BIT];
      end else if (en_clr) begin
        chan_en <= 1'b0;  // Engine finished or aborted
      end
      soft_trig <= wr_sel.soft_req & wdata[dma_chan_pkg::SREQ_BIT];  // Single-cycle pulse
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read back
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ctrl_a_word = '0;
    ctrl_a_word[dma_chan_pkg::CA_DGRP_BIT] = cfg.dst_grp_addr;
    ctrl_a_word[dma_chan_pkg::CA_SGRP_BIT] = cfg.src_grp_addr;
    ctrl_a_word[dma_chan_pkg::CA_GRPM_BIT] = cfg.grp_mode;
    ctrl_a_word[dma_chan_pkg::CA_INTM_LSB +: dma_chan_pkg::INT_MODE_W] = cfg.int_mode;
    ctrl_a_word[dma_chan_pkg::CA_BTL_LSB +: dma_chan_pkg::BTL_W] = cfg.block_len;
    ctrl_a_word[dma_chan_pkg::CA_GLEN_LSB +: dma_chan_pkg::GLEN_LO_W] =
      cfg.group_len[dma_chan_pkg::GLEN_LO_W-1:0];
    ctrl_a_word[dma_chan_pkg::CA_SINC_LSB +: 2] = cfg.src_inc;
    ctrl_a_word[dma_chan_pkg::CA_DINC_LSB +: 2] = cfg.dst_inc;
    ctrl_a_word[dma_chan_pkg::CA_SWID_LSB +: 2] = cfg.src_width;
    ctrl_a_word[dma_chan_pkg::CA_DWID_LSB +: 2] = cfg.dst_width;

    ctrl_b_word = '0;
    ctrl_b_word[dma_chan_pkg::CB_PROT_LSB +: dma_chan_pkg::PROT_W] = cfg.prot;
    ctrl_b_word[dma_chan_pkg::CB_ENDIAN_BIT] = cfg.endian;
    ctrl_b_word[dma_chan_pkg::CB_SDL_BIT] = cfg.src_dlogic;
    ctrl_b_word[dma_chan_pkg::CB_TRIG_LSB +: dma_chan_pkg::TRIG_W] = cfg.trig_mode;
    ctrl_b_word[dma_chan_pkg::CB_IE_BIT] = int_en;

    ext_word = '0;
    ext_word[dma_chan_pkg::GX_GLEN_LSB +: dma_chan_pkg::GLEN_HI_W] =
      cfg.group_len[dma_chan_pkg::GLEN_LO_W +: dma_chan_pkg::GLEN_HI_W];

    en_word = '0;
    en_word[dma_chan_pkg::EN_BIT] = chan_en;
  end

  // Read strobes are one-hot, so the order here does not matter
  always_comb begin
    cfg_rdata = '0;
    if (rd_sel.sarn) cfg_rdata = cfg.sarn;
    if (rd_sel.darn) cfg_rdata = cfg.darn;
    if (rd_sel.ctrl_a) cfg_rdata = ctrl_a_word;
    if (rd_sel.ctrl_b) cfg_rdata = ctrl_b_word;
    if (rd_sel.grp_ext) cfg_rdata = ext_word;
    if (rd_sel.en) cfg_rdata = en_word;
  end

endmodule

/* hdl/chan_bus_slave.sv */
// Zero-wait AHB-style slave front end with no ready and no error response
// Only the low DEC_ADDR_W address bits are decoded, so the map aliases above them
// Strobes are registered at the address-phase edge and used in the data phase
module chan_bus_slave #(
  parameter dma_chan_pkg::dec_addr_t BASE_ADDR = 10'h030
) (
  input  logic                   hclk,
  input  logic                   hrst_n,
  input  dma_chan_pkg::ahb_req_t  s_req,
  input  dma_chan_pkg::reg_word_t s_wdata,
  input  dma_chan_pkg::reg_word_t cfg_rdata,
  input  dma_chan_pkg::reg_word_t irq_rdata,
  output dma_chan_pkg::reg_sel_t  wr_sel,
  output dma_chan_pkg::reg_sel_t  rd_sel,
  output dma_chan_pkg::reg_word_t wdata,
  output dma_chan_pkg::reg_word_t s_rdata
);

  logic                    live;
  dma_chan_pkg::dec_addr_t dec;
  dma_chan_pkg::reg_sel_t  hit;
  dma_chan_pkg::reg_sel_t  wr_nxt;
  dma_chan_pkg::reg_sel_t  rd_nxt;

  function automatic logic at_ofs(input dma_chan_pkg::dec_addr_t a,
                                  input dma_chan_pkg::dec_addr_t ofs);
    return a == BASE_ADDR + ofs;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address phase decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign live = s_req.sel && (s_req.trans == dma_chan_pkg::NONSEQ ||
                              s_req.trans == dma_chan_pkg::SEQ);
  assign dec  = s_req.addr[dma_chan_pkg::DEC_ADDR_W-1:0];

  always_comb begin
    hit.sarn       = at_ofs(dec, dma_chan_pkg::OFS_SARN);
    hit.darn       = at_ofs(dec, dma_chan_pkg::OFS_DARN);
    hit.ctrl_a     = at_ofs(dec, dma_chan_pkg::OFS_CTRL_A);
    hit.ctrl_b     = at_ofs(dec, dma_chan_pkg::OFS_CTRL_B);
    hit.int_mask   = at_ofs(dec, dma_chan_pkg::OFS_INT_MASK);
    hit.int_status = at_ofs(dec, dma_chan_pkg::OFS_INT_STATUS);
    hit.int_clear  = at_ofs(dec, dma_chan_pkg::OFS_INT_CLEAR);
    hit.soft_req   = at_ofs(dec, dma_chan_pkg::OFS_SOFT_REQ);
    hit.en         = at_ofs(dec, dma_chan_pkg::OFS_EN);
    hit.grp_ext    = at_ofs(dec, dma_chan_pkg::OFS_GRP_EXT);
  end

  always_comb begin
    wr_nxt = (live && s_req.write) ? hit : '0;
    wr_nxt.int_status = 1'b0;  // Status is read only
    rd_nxt = (live && !s_req.write) ? hit : '0;
    rd_nxt.int_clear = 1'b0;  // Clear and soft request are write only
    rd_nxt.soft_req  = 1'b0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data phase strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      wr_sel <= '0;
      rd_sel <= '0;
    end else begin
      wr_sel <= wr_nxt;
      rd_sel <= rd_nxt;
    end
  end

  // Master holds write data for the whole data phase
  assign wdata = s_wdata;

  // Each block returns zero unless one of its own read strobes is set
  assign s_rdata = cfg_rdata | irq_rdata;

endmodule

/* hdl/dma_chan_pkg.sv */
// Shared types, register map and field layout of one DMA channel register block
// Offsets are relative to the channel base and decoded on the low 10 address bits
// Bits outside the listed fields read as zero and are ignored on write
package dma_chan_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DEC_ADDR_W = 10;
  localparam int IRQ_W      = 5;
  localparam int BTL_W      = 12;
  localparam int GLEN_LO_W  = 4;
  localparam int GLEN_HI_W  = 2;
  localparam int INT_MODE_W = 3;
  localparam int PROT_W     = 4;
  localparam int TRIG_W     = 2;

  typedef logic [31:0]                    reg_word_t;
  typedef logic [DEC_ADDR_W-1:0]          dec_addr_t;
  typedef logic [BTL_W-1:0]               block_tl_t;
  typedef logic [GLEN_HI_W+GLEN_LO_W-1:0] group_len_t;
  typedef logic [1:0]                     width_code_t;
  typedef logic [1:0]                     addr_inc_t;
  typedef logic [IRQ_W-1:0]               irq_vec_t;  // Pend, trg cmp, half, done, err

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register offsets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam dec_addr_t OFS_SARN       = 10'h000;
  localparam dec_addr_t OFS_DARN       = 10'h004;
  localparam dec_addr_t OFS_CTRL_A     = 10'h008;
  localparam dec_addr_t OFS_CTRL_B     = 10'h00C;
  localparam dec_addr_t OFS_INT_MASK   = 10'h010;
  localparam dec_addr_t OFS_INT_STATUS = 10'h014;
  localparam dec_addr_t OFS_INT_CLEAR  = 10'h018;
  localparam dec_addr_t OFS_SOFT_REQ   = 10'h01C;
  localparam dec_addr_t OFS_EN         = 10'h020;
  localparam dec_addr_t OFS_GRP_EXT    = 10'h024;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field positions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int CA_DGRP_BIT   = 31;
  localparam int CA_SGRP_BIT   = 29;
  localparam int CA_GRPM_BIT   = 28;
  localparam int CA_INTM_LSB   = 24;
  localparam int CA_BTL_LSB    = 12;
  localparam int CA_GLEN_LSB   = 8;
  localparam int CA_SINC_LSB   = 6;
  localparam int CA_DINC_LSB   = 4;
  localparam int CA_SWID_LSB   = 2;
  localparam int CA_DWID_LSB   = 0;
  localparam int CB_PROT_LSB   = 15;
  localparam int CB_ENDIAN_BIT = 14;
  localparam int CB_SDL_BIT    = 13;
  localparam int CB_TRIG_LSB   = 1;
  localparam int CB_IE_BIT     = 0;
  localparam int GX_GLEN_LSB   = 0;  // Lands on group_len[5:4]
  localparam int EN_BIT        = 0;
  localparam int SREQ_BIT      = 0;
  localparam int IRQ_PEND_BIT  = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic      sel;
    htrans_e   trans;
    reg_word_t addr;
    logic      write;
  } ahb_req_t;

  typedef struct packed {
    logic sarn;
    logic darn;
    logic ctrl_a;
    logic ctrl_b;
    logic int_mask;
    logic int_status;
    logic int_clear;
    logic soft_req;
    logic en;
    logic grp_ext;
  } reg_sel_t;

  typedef struct packed {
    reg_word_t             sarn;
    reg_word_t             darn;
    logic                  dst_grp_addr;
    logic                  src_grp_addr;
    logic                  grp_mode;
    logic [INT_MODE_W-1:0] int_mode;
    block_tl_t             block_len;
    group_len_t            group_len;
    addr_inc_t             src_inc;
    addr_inc_t             dst_inc;
    width_code_t           src_width;
    width_code_t           dst_width;
    logic [PROT_W-1:0]     prot;
    logic                  endian;
    logic                  src_dlogic;
    logic [TRIG_W-1:0]     trig_mode;
  } chan_cfg_t;

endpackage
